// File: build.f
+incdir+.
rv_isa_pkg.sv
trace_pkg.sv
insn_decoder.sv
trace_fifo.sv
trace_ctrl.sv
trace_top.sv
trace_asserts.sv
tb_trace.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_trace \
		-Mdir obj_dir -f build.f
	./obj_dir/Vtb_trace > sim.log 2>&1; cat sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_trace.sv
/*
 * Testbench for the retirement trace unit. Retires generated RV32
 * instructions, reads the records back over Wishbone and compares them
 * with a reference decode. Compile with build.f, top module tb_trace.
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module tb_trace;
  import rv_isa_pkg::*;

  localparam int          CLK_PERIOD  = 40;
  localparam int          TEST_CYCLES = 1600;
  localparam int          ACK_LIMIT   = 8;
  localparam int          DEPTH       = `TRACE_FIFO_DEPTH;
  localparam logic [31:0] LFSR_TAPS   = 32'hB4BC_D35C;

  typedef struct packed {
    xlen_t pc;
    xlen_t insn;
    xlen_t info;
    xlen_t operand;
    xlen_t cycle;
    xlen_t rddata;
  } rec_t;

  logic        clk_i;
  logic        rst_ni;
  logic [1:0]  retire_valid;
  logic [63:0] retire_insn;
  logic [63:0] retire_pc;
  logic [63:0] retire_pc_next;
  logic [63:0] retire_rd_wdata;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  xlen_t       wb_dat_w;
  xlen_t       wb_dat_r;
  logic        wb_ack;

  rec_t        exp_q [$];
  logic [31:0] lfsr_state = 32'd93;
  logic [31:0] tb_cycle;
  logic [15:0] tb_ovf;
  int          checks;
  int          errors;
  int          err_base;

  trace_top DUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .retire_valid    (retire_valid),
    .retire_insn     (retire_insn),
    .retire_pc       (retire_pc),
    .retire_pc_next  (retire_pc_next),
    .retire_rd_wdata (retire_rd_wdata),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Cycle count starting at 0 in the first cycle out of reset
  always @(posedge clk_i) begin : cycle_model
    if (rst_ni) tb_cycle <= '0;
    else tb_cycle <= tb_cycle + 32'd1;
  end

  // Four cycles of slack per estimated test cycle
  initial begin : watchdog
    #(TEST_CYCLES * 4 * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("** FAIL **");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and instruction generation

  function automatic logic next_random_bit();
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_random_bit()};
    return v;
  endfunction

  function automatic insn_t make_insn(insn_class_e cls, int variant);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [19:0] upper;
    insn_t       w;
    rd    = 5'(random_bits(5));
    rs1   = 5'(random_bits(5));
    rs2   = 5'(random_bits(5));
    f3    = 3'(random_bits(3));
    imm   = 12'(random_bits(12));
    upper = 20'(random_bits(20));
    w     = '0;
    case (cls)
      ALU_R: begin
        if (variant[0]) w = {7'h20, rs2, rs1, (f3[0] ? 3'd5 : 3'd0), rd, 7'h33};
        else w = {7'h00, rs2, rs1, f3, rd, 7'h33};
      end
      MULDIV: w = {7'h01, rs2, rs1, f3, rd, 7'h33};
      ALU_I: begin
        // Keep clear of the shift encodings
        if (f3 == 3'd1 || f3 == 3'd5) f3 = f3 - 3'd1;
        w = {imm, rs1, f3, rd, 7'h13};
      end
      SHIFT_I: begin
        if (variant[0]) w = {(f3[0] ? 7'h20 : 7'h00), rs2, rs1, 3'd5, rd, 7'h13};
        else w = {7'h00, rs2, rs1, 3'd1, rd, 7'h13};
      end
      LUI:   w = {upper, rd, 7'h37};
      AUIPC: w = {upper, rd, 7'h17};
      JAL:   w = {upper, rd, 7'h6f};
      JALR:  w = {imm, rs1, 3'd0, rd, 7'h67};
      BRANCH: begin
        if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd4;
        w = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h63};
      end
      LOAD: begin
        if (f3 == 3'd3 || f3 >= 3'd6) f3 = f3 & 3'b101;
        w = {imm, rs1, f3, rd, 7'h03};
      end
      STORE: begin
        f3 = {1'b0, f3[1:0]};
        if (f3 == 3'd3) f3 = 3'd2;
        w = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
      end
      // Variant 1 gives the immediate forms with bit 14 set
      CSR: begin
        f3 = {variant[0], (f3[1:0] == 2'b00) ? 2'b01 : f3[1:0]};
        w  = {imm, rs1, f3, rd, 7'h73};
      end
      FENCE: w = {imm, rs1, {2'b00, variant[0]}, rd, 7'h0f};
      SYSTEM: begin
        case (f3)
          3'd0:    w = 32'h0000_0073;
          3'd1:    w = 32'h0010_0073;
          3'd2:    w = 32'h3020_0073;
          3'd3:    w = 32'h7b20_0073;
          default: w = 32'h1050_0073;
        endcase
      end
      INVALID: begin
        if (variant == 0) begin
          // Compressed encoding space
          w = random_bits(32);
          if (w[1:0] == 2'b11) w[1:0] = 2'b01;
        end else if (variant == 1) begin
          f3 = f3[0] ? 3'd3 : (f3[1] ? 3'd6 : 3'd7);
          w  = {imm, rs1, f3, rd, 7'h03};
        end else begin
          if (f3 < 3'd3) f3 = f3 + 3'd3;
          w = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
        end
      end
      default: w = '0;
    endcase
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference decode into {INFO, OPERAND}

  function automatic logic [63:0] expected_info_operand(insn_t w, xlen_t pc, xlen_t pc_next);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [3:0]  mask;
    insn_class_e cls;
    xlen_t       op;
    xlen_t       info;
    f3  = w[14:12];
    f7  = w[31:25];
    cls = INVALID;
    if (w[1:0] == 2'b11) begin
      case (w[6:0])
        7'h37: cls = LUI;
        7'h17: cls = AUIPC;
        7'h6f: cls = JAL;
        7'h67: if (f3 == 3'd0) cls = JALR;
        7'h63: if (f3 != 3'd2 && f3 != 3'd3) cls = BRANCH;
        7'h03: if (f3 != 3'd3 && f3 < 3'd6) cls = LOAD;
        7'h23: if (f3 < 3'd3) cls = STORE;
        7'h13: begin
          if (f3 == 3'd1) begin
            if (f7 == 7'h00) cls = SHIFT_I;
          end else if (f3 == 3'd5) begin
            if (f7 == 7'h00 || f7 == 7'h20) cls = SHIFT_I;
          end else begin
            cls = ALU_I;
          end
        end
        7'h33: begin
          if (f7 == 7'h01) cls = MULDIV;
          else if (f7 == 7'h00) cls = ALU_R;
          else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) cls = ALU_R;
        end
        7'h0f: if (f3 <= 3'd1) cls = FENCE;
        7'h73: begin
          if (f3 != 3'd0 && f3 != 3'd4) cls = CSR;
          else if (w == 32'h0000_0073 || w == 32'h0010_0073 || w == 32'h3020_0073 ||
                   w == 32'h7b20_0073 || w == 32'h1050_0073) cls = SYSTEM;
        end
        default: cls = INVALID;
      endcase
    end

    // Mask bits are {MEM, RD, RS2, RS1}
    case (cls)
      ALU_R, MULDIV:        mask = 4'b0111;
      ALU_I, SHIFT_I, JALR: mask = 4'b0101;
      LUI, AUIPC, JAL:      mask = 4'b0100;
      BRANCH:               mask = 4'b0011;
      LOAD:                 mask = 4'b1101;
      STORE:                mask = 4'b1011;
      CSR:                  mask = w[14] ? 4'b0100 : 4'b0101;
      default:              mask = 4'b0000;
    endcase
    if (w[11:7] == 5'd0) mask[2] = 1'b0;

    case (cls)
      ALU_I, JALR, LOAD: op = {{20{w[31]}}, w[31:20]};
      STORE:             op = {{20{w[31]}}, w[31:25], w[11:7]};
      SHIFT_I:           op = {27'd0, w[24:20]};
      LUI, AUIPC:        op = {12'd0, w[31:12]};
      BRANCH:            op = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      JAL:               op = pc_next;
      CSR:               op = {20'd0, w[31:20]};
      default:           op = '0;
    endcase

    info = {9'd0, cls, mask, w[11:7], w[19:15], w[24:20]};
    return {info, op};
  endfunction

  function automatic xlen_t expected_status();
    return {tb_ovf, 8'h00, 8'(exp_q.size())};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Driving and checking

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic wb_access(input logic we, input logic [2:0] adr, input xlen_t wdata,
                           output xlen_t rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    do begin
      @(posedge clk_i);
      #1;
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    rdata = wb_dat_r;
    if (!wb_ack) begin
      $display("Wishbone access to offset %0d got no ack within %0d cycles", adr, ACK_LIMIT);
      errors++;
    end else begin
      // Ack belongs in the cycle right after the strobe
      check("wb_ack edges", xlen_t'(waited), 32'd1);
    end
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    next_cycle();
  endtask

  task automatic wb_read(input logic [2:0] adr, output xlen_t data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic wb_write(input logic [2:0] adr, input xlen_t data);
    xlen_t unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  // One retirement cycle with lane 0 admitted before lane 1
  task automatic retire(input logic [1:0] valid, input insn_t insn0, input insn_t insn1);
    insn_t       w [2];
    xlen_t       pc [2];
    xlen_t       pcn [2];
    xlen_t       wd [2];
    logic [63:0] io;
    rec_t        r;
    w[0] = insn0;
    w[1] = insn1;
    for (int i = 0; i < 2; i++) begin
      pc[i]  = random_bits(30) << 2;
      pcn[i] = random_bits(30) << 2;
      wd[i]  = random_bits(32);
      retire_insn[i*32 +: 32]     = w[i];
      retire_pc[i*32 +: 32]       = pc[i];
      retire_pc_next[i*32 +: 32]  = pcn[i];
      retire_rd_wdata[i*32 +: 32] = wd[i];
      if (valid[i]) begin
        io = expected_info_operand(w[i], pc[i], pcn[i]);
        r  = '{pc: pc[i], insn: w[i], info: io[63:32], operand: io[31:0], cycle: tb_cycle,
               rddata: wd[i]};
        if (exp_q.size() < DEPTH) exp_q.push_back(r);
        else if (tb_ovf != 16'hffff) tb_ovf++;
      end
    end
    retire_valid = valid;
    next_cycle();
    retire_valid = 2'b00;
  endtask

  task automatic read_record();
    rec_t  e;
    xlen_t v;
    e = exp_q.pop_front();
    wb_read(`TRACE_REG_PC, v);
    check("PC", v, e.pc);
    wb_read(`TRACE_REG_INSN, v);
    check("INSN", v, e.insn);
    wb_read(`TRACE_REG_INFO, v);
    check("INFO", v, e.info);
    wb_read(`TRACE_REG_OPERAND, v);
    check("OPERAND", v, e.operand);
    wb_read(`TRACE_REG_CYCLE, v);
    check("CYCLE", v, e.cycle);
    wb_read(`TRACE_REG_RDDATA, v);
    check("RDDATA", v, e.rddata);
    wb_write(`TRACE_REG_POP, random_bits(32));
  endtask

  task automatic drain();
    xlen_t v;
    wb_read(`TRACE_REG_STATUS, v);
    check("STATUS", v, expected_status());
    while (exp_q.size() > 0) read_record();
    wb_read(`TRACE_REG_STATUS, v);
    check("STATUS", v, expected_status());
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %s, %0d mismatches", num, name,
             (errors == err_base) ? "ok" : "errors", errors - err_base);
    err_base = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin : main
    xlen_t v;
    insn_t w0;
    retire_valid    = '0;
    retire_insn     = '0;
    retire_pc       = '0;
    retire_pc_next  = '0;
    retire_rd_wdata = '0;
    wb_cyc          = 1'b0;
    wb_stb          = 1'b0;
    wb_we           = 1'b0;
    wb_adr          = '0;
    wb_dat_w        = '0;
    tb_ovf          = '0;
    checks          = 0;
    errors          = 0;
    err_base        = 0;
    rst_ni          = 1'b1;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b0;
    next_cycle();

    // Empty unit after reset
    wb_read(`TRACE_REG_STATUS, v);
    check("STATUS", v, 32'h0);
    wb_read(`TRACE_REG_PC, v);
    check("PC", v, 32'h0);
    wb_write(`TRACE_REG_POP, 32'hffff_ffff);
    wb_read(`TRACE_REG_STATUS, v);
    check("STATUS", v, 32'h0);
    end_test(1, "reset and empty pop");

    // Every valid class on lane 0 alone then on lane 1 alone
    for (int c = 0; c < 14; c++) begin
      retire(2'b01, make_insn(insn_class_e'(c), 0), '0);
      retire(2'b10, '0, make_insn(insn_class_e'(c), 1));
      drain();
    end
    end_test(2, "single lane classes");

    // Writes to x0 and invalid encodings
    w0 = make_insn(ALU_I, 0);
    w0[11:7] = 5'd0;
    retire(2'b01, w0, '0);
    w0 = make_insn(LUI, 0);
    w0[11:7] = 5'd0;
    retire(2'b01, w0, '0);
    w0 = make_insn(CSR, 0);
    w0[11:7] = 5'd0;
    retire(2'b01, w0, '0);
    drain();
    for (int k = 0; k < 3; k++) retire(2'b01, make_insn(INVALID, k), '0);
    retire(2'b10, '0, make_insn(INVALID, 0));
    drain();
    end_test(3, "x0 and invalid");

    // Both lanes in one cycle
    for (int k = 0; k < 4; k++) begin
      retire(2'b11, make_insn(insn_class_e'(random_bits(4) % 14), k),
             make_insn(insn_class_e'(random_bits(4) % 14), k + 1));
    end
    drain();
    end_test(4, "dual lane order");

    // Overflow past the FIFO depth
    for (int k = 0; k < 20; k++) retire(2'b01, make_insn(insn_class_e'(k % 14), k % 2), '0);
    wb_read(`TRACE_REG_STATUS, v);
    check("STATUS", v, 32'h0004_0010);
    drain();
    end_test(5, "overflow");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: trace_asserts.sv
/*
 * Concurrent checks on the Wishbone handshake and the FIFO occupancy.
 * Bound into every trace_top instance by the bind at the end.
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module trace_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 wb_cyc,
  input logic                 wb_stb,
  input logic                 wb_ack,
  input trace_pkg::fifo_cnt_t count
);
  import trace_pkg::*;

  localparam fifo_cnt_t DEPTH = fifo_cnt_t'(`TRACE_FIFO_DEPTH);

  // Ack answers a strobe seen on the previous edge
  ack_follows_request: assert property (@(posedge clk_i) disable iff (rst_ni)
      wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack raised without a request in the previous cycle");

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (rst_ni)
      wb_ack |=> !wb_ack)
    else $error("wb_ack held high for two cycles");

  count_in_range: assert property (@(posedge clk_i) disable iff (rst_ni)
      count <= DEPTH)
    else $error("FIFO count above the depth");

endmodule

bind trace_top trace_asserts u_asserts (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .count  (count)
);

`default_nettype wire

// File: trace_top.sv
/*
 * Retirement trace capture top level. Decodes both retirement lanes,
 * queues the records and serves them over a Wishbone classic slave.
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module trace_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [`TRACE_LANES-1:0]     retire_valid,
  input  logic [`TRACE_LANES*32-1:0]  retire_insn,
  input  logic [`TRACE_LANES*32-1:0]  retire_pc,
  input  logic [`TRACE_LANES*32-1:0]  retire_pc_next,
  input  logic [`TRACE_LANES*32-1:0]  retire_rd_wdata,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [2:0]                  wb_adr,
  input  rv_isa_pkg::xlen_t           wb_dat_w,
  output rv_isa_pkg::xlen_t           wb_dat_r,
  output logic                        wb_ack
);
  import rv_isa_pkg::*;
  import trace_pkg::*;

  insn_class_e  lane_class   [`TRACE_LANES];
  access_mask_t lane_access  [`TRACE_LANES];
  reg_addr_t    lane_rd      [`TRACE_LANES];
  reg_addr_t    lane_rs1     [`TRACE_LANES];
  reg_addr_t    lane_rs2     [`TRACE_LANES];
  xlen_t        lane_operand [`TRACE_LANES];
  xlen_t        lane_info    [`TRACE_LANES];
  logic         push0;
  logic         push1;
  logic         pop;
  fifo_cnt_t    count;
  cycle_t       cycle;
  xlen_t        head_pc;
  xlen_t        head_insn;
  xlen_t        head_info;
  xlen_t        head_operand;
  xlen_t        head_cycle;
  xlen_t        head_rddata;

  for (genvar i = 0; i < `TRACE_LANES; i++) begin : g_lane
    insn_decoder u_dec (
      .insn       (retire_insn[i*32 +: 32]),
      .pc         (retire_pc[i*32 +: 32]),
      .pc_next    (retire_pc_next[i*32 +: 32]),
      .insn_class (lane_class[i]),
      .access     (lane_access[i]),
      .rd         (lane_rd[i]),
      .rs1        (lane_rs1[i]),
      .rs2        (lane_rs2[i]),
      .operand    (lane_operand[i])
    );

    assign lane_info[i] = info_word(lane_class[i], lane_access[i], lane_rd[i],
                                    lane_rs1[i], lane_rs2[i]);
  end

  // Both lanes of one cycle share the same stamp
  trace_fifo u_fifo (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push0          (push0),
    .push1          (push1),
    .pop            (pop),
    .wdata0_pc      (retire_pc[31:0]),
    .wdata0_insn    (retire_insn[31:0]),
    .wdata0_info    (lane_info[0]),
    .wdata0_operand (lane_operand[0]),
    .wdata0_cycle   (cycle),
    .wdata0_rddata  (retire_rd_wdata[31:0]),
    .wdata1_pc      (retire_pc[63:32]),
    .wdata1_insn    (retire_insn[63:32]),
    .wdata1_info    (lane_info[1]),
    .wdata1_operand (lane_operand[1]),
    .wdata1_cycle   (cycle),
    .wdata1_rddata  (retire_rd_wdata[63:32]),
    .head_pc        (head_pc),
    .head_insn      (head_insn),
    .head_info      (head_info),
    .head_operand   (head_operand),
    .head_cycle     (head_cycle),
    .head_rddata    (head_rddata),
    .count          (count)
  );

  trace_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .retire_valid (retire_valid),
    .count        (count),
    .head_pc      (head_pc),
    .head_insn    (head_insn),
    .head_info    (head_info),
    .head_operand (head_operand),
    .head_cycle   (head_cycle),
    .head_rddata  (head_rddata),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .push0        (push0),
    .push1        (push1),
    .pop          (pop),
    .cycle        (cycle),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack)
  );

endmodule

`default_nettype wire

// File: trace_ctrl.sv
/*
 * Cycle stamp, lane admission with overflow counting, and the Wishbone
 * classic slave that reads the head record and pops it on request.
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module trace_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`TRACE_LANES-1:0]  retire_valid,
  input  trace_pkg::fifo_cnt_t     count,
  input  rv_isa_pkg::xlen_t        head_pc,
  input  rv_isa_pkg::xlen_t        head_insn,
  input  rv_isa_pkg::xlen_t        head_info,
  input  rv_isa_pkg::xlen_t        head_operand,
  input  rv_isa_pkg::xlen_t        head_cycle,
  input  rv_isa_pkg::xlen_t        head_rddata,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [2:0]               wb_adr,
  input  rv_isa_pkg::xlen_t        wb_dat_w,
  output logic                     push0,
  output logic                     push1,
  output logic                     pop,
  output trace_pkg::cycle_t        cycle,
  output rv_isa_pkg::xlen_t        wb_dat_r,
  output logic                     wb_ack
);
  import rv_isa_pkg::*;
  import trace_pkg::*;

  localparam fifo_cnt_t DEPTH = fifo_cnt_t'(`TRACE_FIFO_DEPTH);
  localparam int        OVF_W = $bits(ovf_cnt_t);

  typedef enum logic {IDLE, ACK} wb_state_e;

  wb_state_e      state_q;
  wb_state_e      state_d;
  cycle_t         cycle_q;
  ovf_cnt_t       ovf_q;
  logic [1:0]     drops;
  logic [OVF_W:0] ovf_sum;
  logic           fifo_empty;
  logic           req;
  xlen_t          rd_mux;
  xlen_t          dat_q;

  //////////////////////////////////////////////////////////////////////
  // Admission, lane 1 only gets a slot left over by lane 0
  assign push0 = retire_valid[0] && (count < DEPTH);
  assign push1 = retire_valid[1] && ((count + fifo_cnt_t'(push0)) < DEPTH);

  assign drops   = {1'b0, retire_valid[0] & ~push0} + {1'b0, retire_valid[1] & ~push1};
  assign ovf_sum = {1'b0, ovf_q} + {{(OVF_W-1){1'b0}}, drops};

  //////////////////////////////////////////////////////////////////////
  // Wishbone slave
  assign fifo_empty = (count == '0);
  assign req        = wb_cyc && wb_stb && (state_q == IDLE);

  // Head leaves the FIFO on the same edge that raises ack
  assign pop = req && wb_we && (wb_adr == `TRACE_REG_POP) && !fifo_empty;

  always_comb begin : read_mux
    case (wb_adr)
      `TRACE_REG_STATUS:  rd_mux = status_word(count, ovf_q);
      `TRACE_REG_PC:      rd_mux = head_pc;
      `TRACE_REG_INSN:    rd_mux = head_insn;
      `TRACE_REG_INFO:    rd_mux = head_info;
      `TRACE_REG_OPERAND: rd_mux = head_operand;
      `TRACE_REG_CYCLE:   rd_mux = head_cycle;
      `TRACE_REG_RDDATA:  rd_mux = head_rddata;
      default:            rd_mux = '0;
    endcase
    // Record words of an empty FIFO read as zero
    if (fifo_empty && wb_adr != `TRACE_REG_STATUS) rd_mux = '0;
  end

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      IDLE:    if (wb_cyc && wb_stb) state_d = ACK;
      ACK:     state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin : ctrl_regs
    if (rst_ni) begin
      state_q <= IDLE;
      cycle_q <= '0;
      ovf_q   <= '0;
    end else begin
      state_q <= state_d;
      cycle_q <= cycle_q + 1'b1;
      ovf_q   <= ovf_sum[OVF_W] ? '1 : ovf_sum[OVF_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin : read_data
    if (req) dat_q <= rd_mux;
  end

  assign wb_ack   = (state_q == ACK);
  assign wb_dat_r = dat_q;
  assign cycle    = cycle_q;

endmodule

`default_nettype wire

// File: trace_fifo.sv
/*
 * Circular record store, two writes and one read per cycle.
 * Lane 0 goes to the first free slot, lane 1 right behind it.
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module trace_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push0,
  input  logic                  push1,
  input  logic                  pop,
  input  rv_isa_pkg::xlen_t     wdata0_pc,
  input  rv_isa_pkg::xlen_t     wdata0_insn,
  input  rv_isa_pkg::xlen_t     wdata0_info,
  input  rv_isa_pkg::xlen_t     wdata0_operand,
  input  rv_isa_pkg::xlen_t     wdata0_cycle,
  input  rv_isa_pkg::xlen_t     wdata0_rddata,
  input  rv_isa_pkg::xlen_t     wdata1_pc,
  input  rv_isa_pkg::xlen_t     wdata1_insn,
  input  rv_isa_pkg::xlen_t     wdata1_info,
  input  rv_isa_pkg::xlen_t     wdata1_operand,
  input  rv_isa_pkg::xlen_t     wdata1_cycle,
  input  rv_isa_pkg::xlen_t     wdata1_rddata,
  output rv_isa_pkg::xlen_t     head_pc,
  output rv_isa_pkg::xlen_t     head_insn,
  output rv_isa_pkg::xlen_t     head_info,
  output rv_isa_pkg::xlen_t     head_operand,
  output rv_isa_pkg::xlen_t     head_cycle,
  output rv_isa_pkg::xlen_t     head_rddata,
  output trace_pkg::fifo_cnt_t  count
);
  import rv_isa_pkg::*;
  import trace_pkg::*;

  localparam int DEPTH   = `TRACE_FIFO_DEPTH;
  localparam int PTR_W   = $clog2(DEPTH);
  localparam int ENTRY_W = 6 * $bits(xlen_t);

  typedef logic [ENTRY_W-1:0] entry_t;

  entry_t           mem [DEPTH];
  entry_t           entry0;
  entry_t           entry1;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] wr_ptr_1;
  logic [PTR_W-1:0] rd_ptr;
  fifo_cnt_t        count_q;

  assign entry0 = {wdata0_pc, wdata0_insn, wdata0_info, wdata0_operand, wdata0_cycle,
                   wdata0_rddata};
  assign entry1 = {wdata1_pc, wdata1_insn, wdata1_info, wdata1_operand, wdata1_cycle,
                   wdata1_rddata};

  // Slot for lane 1 skips past lane 0 only when lane 0 is written
  assign wr_ptr_1 = wr_ptr + PTR_W'(push0);

  always_ff @(posedge clk_i) begin : store
    if (push0) mem[wr_ptr] <= entry0;
    if (push1) mem[wr_ptr_1] <= entry1;
  end

  always_ff @(posedge clk_i) begin : pointers
    if (rst_ni) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      wr_ptr  <= wr_ptr_1 + PTR_W'(push1);
      rd_ptr  <= rd_ptr + PTR_W'(pop);
      count_q <= count_q + fifo_cnt_t'(push0) + fifo_cnt_t'(push1) - fifo_cnt_t'(pop);
    end
  end

  assign {head_pc, head_insn, head_info, head_operand, head_cycle, head_rddata} = mem[rd_ptr];
  assign count = count_q;

endmodule

`default_nettype wire

// File: insn_decoder.sv
/*
 * Combinational decode of one retired RV32 instruction into its trace
 * class, register/memory access mask, register numbers and operand.
 */
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input  rv_isa_pkg::insn_t       insn,
  input  rv_isa_pkg::xlen_t       pc,
  input  rv_isa_pkg::xlen_t       pc_next,
  output rv_isa_pkg::insn_class_e insn_class,
  output trace_pkg::access_mask_t access,
  output rv_isa_pkg::reg_addr_t   rd,
  output rv_isa_pkg::reg_addr_t   rs1,
  output rv_isa_pkg::reg_addr_t   rs2,
  output rv_isa_pkg::xlen_t       operand
);
  import rv_isa_pkg::*;
  import trace_pkg::*;

  opcode_e      opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  xlen_t        imm_i;
  xlen_t        imm_s;
  xlen_t        imm_b;
  access_mask_t mask_raw;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Class match, compressed words fall through to INVALID
  always_comb begin : classify
    insn_class = INVALID;
    if (insn[1:0] == 2'b11) begin
      case (opcode)
        OPC_LUI:   insn_class = LUI;
        OPC_AUIPC: insn_class = AUIPC;
        OPC_JAL:   insn_class = JAL;
        OPC_JALR:  if (funct3 == 3'd0) insn_class = JALR;
        OPC_BRANCH: begin
          if (funct3 != 3'd2 && funct3 != 3'd3) insn_class = BRANCH;
        end
        OPC_LOAD: begin
          if (funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) insn_class = LOAD;
        end
        OPC_STORE: if (funct3 < 3'd3) insn_class = STORE;
        OPC_OP_IMM: begin
          if (funct3 == 3'd1) begin
            if (funct7 == F7_BASE) insn_class = SHIFT_I;
          end else if (funct3 == 3'd5) begin
            if (funct7 inside {F7_BASE, F7_ALT}) insn_class = SHIFT_I;
          end else begin
            insn_class = ALU_I;
          end
        end
        OPC_OP: begin
          if (funct7 == F7_BASE) begin
            insn_class = ALU_R;
          end else if (funct7 == F7_ALT && funct3 inside {3'd0, 3'd5}) begin
            insn_class = ALU_R;
          end else if (funct7 == F7_MULDIV) begin
            insn_class = MULDIV;
          end
        end
        OPC_MISC_MEM: if (funct3 inside {3'd0, 3'd1}) insn_class = FENCE;
        OPC_SYSTEM: begin
          // funct3 of 0 and 4 carry no CSR access
          if (funct3 != 3'd0 && funct3 != 3'd4) begin
            insn_class = CSR;
          end else if (insn inside {INSN_ECALL, INSN_EBREAK, INSN_MRET, INSN_DRET,
                                    INSN_WFI}) begin
            insn_class = SYSTEM;
          end
        end
        default: insn_class = INVALID;
      endcase
    end
  end

  always_comb begin : mask_sel
    case (insn_class)
      ALU_R, MULDIV:       mask_raw = MASK_RS1 | MASK_RS2 | MASK_RD;
      ALU_I, SHIFT_I, JALR: mask_raw = MASK_RS1 | MASK_RD;
      LUI, AUIPC, JAL:     mask_raw = MASK_RD;
      BRANCH:              mask_raw = MASK_RS1 | MASK_RS2;
      LOAD:                mask_raw = MASK_RS1 | MASK_RD | MASK_MEM;
      STORE:               mask_raw = MASK_RS1 | MASK_RS2 | MASK_MEM;
      // Immediate CSR forms read no register
      CSR:                 mask_raw = insn[14] ? MASK_RD : (MASK_RD | MASK_RS1);
      default:             mask_raw = '0;
    endcase
  end

  // Writes to x0 are not traced as register writes
  assign access = (rd == '0) ? (mask_raw & ~MASK_RD) : mask_raw;

  always_comb begin : operand_sel
    case (insn_class)
      ALU_I, JALR, LOAD: operand = imm_i;
      STORE:             operand = imm_s;
      SHIFT_I:           operand = {27'b0, insn[24:20]};
      LUI, AUIPC:        operand = {12'b0, insn[31:12]};
      BRANCH:            operand = pc + imm_b;
      JAL:               operand = pc_next;
      CSR:               operand = {20'b0, insn[31:20]};
      default:           operand = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: trace_pkg.sv
/*
 * Trace record types: access mask, cycle stamp, FIFO occupancy and the
 * packing of the INFO and STATUS words read over Wishbone.
 */
`default_nettype none

`include "trace_defines.svh"

package trace_pkg;

  typedef logic [3:0]                  access_mask_t;
  typedef logic [`TRACE_CYCLE_W-1:0]   cycle_t;
  typedef logic [4:0]                  fifo_cnt_t;
  typedef logic [15:0]                 ovf_cnt_t;

  localparam access_mask_t MASK_RS1 = 4'b0001;
  localparam access_mask_t MASK_RS2 = 4'b0010;
  localparam access_mask_t MASK_RD  = 4'b0100;
  localparam access_mask_t MASK_MEM = 4'b1000;

  // INFO is {zeros, class[22:19], mask[18:15], rd[14:10], rs1[9:5], rs2[4:0]}
  function automatic rv_isa_pkg::xlen_t info_word(rv_isa_pkg::insn_class_e cls,
      access_mask_t mask, rv_isa_pkg::reg_addr_t rd, rv_isa_pkg::reg_addr_t rs1,
      rv_isa_pkg::reg_addr_t rs2);
    return {9'b0, cls, mask, rd, rs1, rs2};
  endfunction

  // Overflow count on top, occupancy in the low byte
  function automatic rv_isa_pkg::xlen_t status_word(fifo_cnt_t cnt, ovf_cnt_t ovf);
    return {ovf, 8'b0, 3'b0, cnt};
  endfunction

endpackage

`default_nettype wire

// File: rv_isa_pkg.sv
/*
 * RV32 instruction set types shared by the decoder and the trace record.
 * Holds the major opcodes, the fixed SYSTEM encodings and the class enum.
 */
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes, low two bits included
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'h03,
    OPC_MISC_MEM = 7'h0f,
    OPC_OP_IMM   = 7'h13,
    OPC_AUIPC    = 7'h17,
    OPC_STORE    = 7'h23,
    OPC_OP       = 7'h33,
    OPC_LUI      = 7'h37,
    OPC_BRANCH   = 7'h63,
    OPC_JALR     = 7'h67,
    OPC_JAL      = 7'h6f,
    OPC_SYSTEM   = 7'h73
  } opcode_e;

  // funct7 values of the OP group
  localparam logic [6:0] F7_BASE   = 7'h00;
  localparam logic [6:0] F7_ALT    = 7'h20;
  localparam logic [6:0] F7_MULDIV = 7'h01;

  // SYSTEM encodings without a CSR access
  localparam insn_t INSN_ECALL  = 32'h0000_0073;
  localparam insn_t INSN_EBREAK = 32'h0010_0073;
  localparam insn_t INSN_MRET   = 32'h3020_0073;
  localparam insn_t INSN_DRET   = 32'h7b20_0073;
  localparam insn_t INSN_WFI    = 32'h1050_0073;

  typedef enum logic [3:0] {
    ALU_R, ALU_I, SHIFT_I, LUI, AUIPC, JAL, JALR, BRANCH,
    LOAD, STORE, CSR, MULDIV, FENCE, SYSTEM, INVALID
  } insn_class_e;

endpackage

`default_nettype wire

// File: trace_defines.svh
/*
 * Build constants for the retirement trace unit: lane count, record
 * FIFO depth, cycle stamp width and the Wishbone register map.
 * Include wherever one of these constants is needed.
 */
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// Retirement lanes of the core, lane 0 is the older one
`define TRACE_LANES 2

// Record entries held before new records are dropped
`define TRACE_FIFO_DEPTH 16

// Width of the free running cycle stamp
`define TRACE_CYCLE_W 32

// Wishbone word offsets
`define TRACE_REG_STATUS  3'd0
`define TRACE_REG_PC      3'd1
`define TRACE_REG_INSN    3'd2
`define TRACE_REG_INFO    3'd3
`define TRACE_REG_OPERAND 3'd4
`define TRACE_REG_CYCLE   3'd5
`define TRACE_REG_RDDATA  3'd6
`define TRACE_REG_POP     3'd7

`endif
